/* Makefile */
VERILATOR ?= verilator
TOP       ?= tpuBench
RTL_TOP   ?= tpuTop
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
SOURCES   := $(wildcard rtl/*.sv bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "No verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/resultChecker.sv */
module resultChecker
    import tpuPkg::*;
(
    input  logic                    clk,
    input  logic                    wbAck,
    input  logic                    wbWe,
    input  wbAdrT                   wbAdr,
    input  wbDatT                   wbDatR,
    input  logic                    resultCheckEn,
    input  logic                    statusCheckEn,
    input  wbDatT                   expStatus,
    input  wbDatT [ResultCount-1:0] expResults,
    output int                      errorCount,
    output int                      checkCount
);

    int    errors = 0;
    int    checks = 0;
    idxT   idx;
    wbDatT expected;

    assign errorCount = errors;
    assign checkCount = checks;
    assign idx        = wbAdr[3:0];
    assign expected   = expResults[idx];

    // ======================================================================
    // Read monitor, sampled mid ack cycle
    // ======================================================================
    always @(negedge clk) begin
        if (wbAck && !wbWe) begin
            if (wbAdr[5:4] == ResultBase[5:4] && resultCheckEn) begin
                checks++;
                if (wbDatR !== expected) begin
                    errors++;
                    $display("ERROR t=%0t wbDatR (result %0d) got %h expected %h",
                             $time, idx, wbDatR, expected);
                end
            end else if (wbAdr == CtrlAddr && statusCheckEn) begin
                checks++;
                if (wbDatR !== expStatus) begin  // bit0 busy, bit1 done
                    errors++;
                    $display("ERROR t=%0t wbDatR (status) got %h expected %h",
                             $time, wbDatR, expStatus);
                end
            end
        end
    end

endmodule

/* bench/tpuBench.sv */
module tpuBench
    import tpuPkg::*;
();

    localparam int ClockPeriod   = 100;
    localparam int DriveDelay    = 10;                  // Inputs change after the edge
    localparam int FileTests     = 4;
    localparam int WordsPerTest  = 3 * ResultCount;     // Weights, activations, expected
    localparam int TestCount     = FileTests + 1;       // Plus the xorshift job
    localparam int PollLimit     = 20;
    localparam int TimeoutCycles = TestCount * (48 * 3 + 15 + 20) + 100;
    localparam logic [31:0] RandomSeed = 32'd20;

    logic  clk;
    logic  rst;
    logic  wbCyc, wbStb, wbWe;
    wbAdrT wbAdr;
    wbDatT wbDatW;
    wbDatT wbDatR;
    logic  wbAck;

    // Expected values shared with the checker
    wbDatT [ResultCount-1:0] expResults;
    wbDatT expStatus;
    logic  resultCheckEn, statusCheckEn;
    int    checkCount, checkErrors;
    int    otherErrors = 0;
    int    cycleCount  = 0;

    logic [7:0]  testMem [FileTests * WordsPerTest];
    weightT      wMat [ResultCount];  // Model of the stored weights, k*4 + c
    actT         aMat [ResultCount];  // r*4 + k
    logic [31:0] rngState;
    bit          sameWeights;

    tpuTop i_tpuTop (
        .clk(clk), .rst(rst),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck)
    );

    resultChecker i_resultChecker (
        .clk(clk), .wbAck(wbAck), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatR(wbDatR),
        .resultCheckEn(resultCheckEn), .statusCheckEn(statusCheckEn),
        .expStatus(expStatus), .expResults(expResults),
        .errorCount(checkErrors), .checkCount(checkCount)
    );

    initial clk = 1'b0;
    always #(ClockPeriod / 2) clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ReLU of one row-column dot product, clamped to 127
    function automatic wbDatT reluDot(input int r, input int c);
        int acc;
        acc = 0;
        for (int k = 0; k < ArraySize; k++) begin
            acc += int'(wMat[k * ArraySize + c]) * int'(aMat[r * ArraySize + k]);
        end
        if (acc < 0) acc = 0;
        if (acc > ResultMax) acc = ResultMax;
        return wbDatT'(acc);
    endfunction

    // Ack comes one cycle after the strobe and lasts one cycle
    task automatic completeAccess(output wbDatT dat);
        @(negedge clk);
        if (wbAck) begin
            $display("Ack already high at t=%0t before the strobe was sampled", $time);
            otherErrors++;
        end
        while (!wbAck) @(negedge clk);
        dat = wbDatR;                                 // Stable mid ack cycle
        @(posedge clk);
        #DriveDelay;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        @(negedge clk);
        if (wbAck) begin
            $display("Ack still high at t=%0t, longer than one cycle", $time);
            otherErrors++;
        end
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic busWrite(input wbAdrT adr, input wbDatT dat);
        wbDatT unused;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = 1'b1;
        wbAdr  = adr;
        wbDatW = dat;
        completeAccess(unused);
    endtask

    task automatic busRead(input wbAdrT adr, output wbDatT dat);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = adr;
        completeAccess(dat);
    endtask

    task automatic readAllResults();
        wbDatT d;
        resultCheckEn = 1'b1;
        for (int i = 0; i < ResultCount; i++) busRead(ResultBase + wbAdrT'(i), d);
    endtask

    // Busy polls go unchecked, the final done word is checked
    task automatic pollDone();
        wbDatT st;
        int    polls;
        polls         = 0;
        st            = 8'h01;
        statusCheckEn = 1'b0;
        while (st[0] && polls < PollLimit) begin
            busRead(CtrlAddr, st);
            polls++;
        end
        if (st[0]) begin
            $display("Run still busy after %0d status polls", polls);
            otherErrors++;
        end
        expStatus     = 8'h02;
        statusCheckEn = 1'b1;
        busRead(CtrlAddr, st);
    endtask

    // Operands from wMat/aMat, expectations already in expResults
    task automatic runJob(input bit writeWeights, input bit disturb);
        wbDatT st;
        if (writeWeights) begin
            for (int i = 0; i < ResultCount; i++) busWrite(WeightBase + wbAdrT'(i), wMat[i]);
        end
        for (int i = 0; i < ResultCount; i++) busWrite(ActBase + wbAdrT'(i), {1'b0, aMat[i]});
        busWrite(CtrlAddr, 8'h00);
        expStatus     = 8'h01;                        // Busy, done cleared by start
        statusCheckEn = 1'b1;
        busRead(CtrlAddr, st);
        if (disturb) begin
            busWrite(CtrlAddr, 8'h00);                // Restart while busy
            busWrite(WeightBase, 8'h80);              // Must not reach the store
            busWrite(ActBase, 8'h7f);
        end
        pollDone();
        readAllResults();
        if (disturb) begin
            // Second pass on the stored operands shows any write that got in while busy
            busWrite(CtrlAddr, 8'h00);
            pollDone();
            readAllResults();
        end
    endtask

    task automatic loadFileTest(input int t, output bit reuse);
        int    base;
        wbDatT modelVal;
        base  = t * WordsPerTest;
        reuse = (t > 0);
        for (int i = 0; i < ResultCount; i++) begin
            if (wMat[i] !== weightT'(testMem[base + i])) reuse = 1'b0;
            wMat[i] = weightT'(testMem[base + i]);
            aMat[i] = actT'(testMem[base + ResultCount + i]);
        end
        for (int i = 0; i < ResultCount; i++) begin
            expResults[i] = testMem[base + 2 * ResultCount + i];
            modelVal      = reluDot(i / ArraySize, i % ArraySize);
            if (modelVal !== expResults[i]) begin
                $display("Data file test %0d lists result %0d as %h but the model gives %h",
                         t, i, expResults[i], modelVal);
                otherErrors++;
            end
        end
    endtask

    // ======================================================================
    // Sequence
    // ======================================================================
    initial begin
        wbDatT idleStatus;
        rst           = 1'b1;
        wbCyc         = 1'b0;
        wbStb         = 1'b0;
        wbWe          = 1'b0;
        wbAdr         = '0;
        wbDatW        = '0;
        expResults    = '0;
        expStatus     = '0;
        resultCheckEn = 1'b0;
        statusCheckEn = 1'b0;
        $readmemh("bench/tpu_testdata.txt", testMem);
        repeat (3) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;

        // Idle status and cleared buffer
        statusCheckEn = 1'b1;
        busRead(CtrlAddr, idleStatus);
        readAllResults();

        for (int t = 0; t < FileTests; t++) begin
            loadFileTest(t, sameWeights);
            runJob(!sameWeights, t == 2);
        end

        // Result region is read only
        busWrite(ResultBase + wbAdrT'(5), 8'h55);
        readAllResults();

        // Small weights keep the xorshift job out of constant saturation
        rngState = RandomSeed;
        for (int i = 0; i < ResultCount; i++) begin
            rngState = xorshift(rngState);
            wMat[i]  = weightT'({{4{rngState[3]}}, rngState[3:0]});
            aMat[i]  = actT'(rngState[12:8]);
        end
        for (int i = 0; i < ResultCount; i++) begin
            expResults[i] = reluDot(i / ArraySize, i % ArraySize);
        end
        runJob(1'b1, 1'b0);

        $display("Summary: %0d checked reads, %0d mismatches, %0d other errors",
                 checkCount, checkErrors, otherErrors);
        if (checkErrors == 0 && otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Hang guard
    initial begin
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: no verdict after %0d cycles", TimeoutCycles);
        $display("Summary: %0d checked reads, %0d mismatches, %0d other errors",
                 checkCount, checkErrors, otherErrors + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* bench/tpu_testdata.txt */
// Each test is three lines of 16 hex bytes: weights w[k][c] at k*4+c (signed),
// activations a[r][k] at r*4+k, expected results r*4+c after ReLU and clamp to 7f
// Test 0: identity weights, results copy the activations
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01
05 10 7f 00 23 01 40 11 00 00 00 00 7e 3c 2a 09
05 10 7f 00 23 01 40 11 00 00 00 00 7e 3c 2a 09
// Test 1: mixed signs, some dot products negative
01 ff 02 00 00 01 fe 03 02 00 01 ff ff 02 00 01
03 01 02 04 0a 00 05 02 01 14 00 03 00 07 09 01
03 06 06 05 12 00 19 00 00 19 00 3f 11 09 00 0d
// Test 2: extreme weights, clamps at both ends
7f 80 40 01 7f 80 40 ff 7f 80 00 01 7f 80 00 ff
01 00 00 00 00 00 00 00 7f 7f 7f 7f 01 01 00 00
7f 00 40 01 00 00 00 00 7f 00 7f 00 7f 00 7f 00
// Test 3: same weights as test 2, only new activations are written
7f 80 40 01 7f 80 40 ff 7f 80 00 01 7f 80 00 ff
02 03 00 00 00 00 05 06 00 01 00 01 0a 00 00 0a
7f 00 7f 00 7f 00 00 00 7f 00 40 00 7f 00 7f 00

/* files.f */
rtl/tpuPkg.sv
rtl/macCell.sv
rtl/systolicArray.sv
rtl/busPort.sv
rtl/sequenceControl.sv
rtl/stepCounter.sv
rtl/operandStore.sv
rtl/resultBuffer.sv
rtl/tpuTop.sv
bench/resultChecker.sv
bench/tpuBench.sv

/* rtl/busPort.sv */
module busPort
    import tpuPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wbCyc,
    input  logic      wbStb,
    input  logic      wbWe,
    input  wbAdrT     wbAdr,
    input  wbDatT     wbDatW,
    output wbDatT     wbDatR,
    output logic      wbAck,
    input  logic      busy,
    input  statusT    status,
    input  resultT    resultRdData,
    output operandWrT operandWr,
    output logic      operandWrEn,
    output logic      start,
    output idxT       resultRdIdx
);

    logic inWeights, inActs, inCtrl, inResults;  // Region decode
    logic wrCycle;                               // Write in its ack cycle

    // Regions are 16 words each, picked by the upper two address bits
    assign inWeights = (wbAdr[5:4] == WeightBase[5:4]);
    assign inActs    = (wbAdr[5:4] == ActBase[5:4]);
    assign inResults = (wbAdr[5:4] == ResultBase[5:4]);
    assign inCtrl    = (wbAdr == CtrlAddr);  // Only the one word is mapped

    // Single cycle ack, one cycle after the strobe is seen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= wbCyc && wbStb && !wbAck;  // Master drops stb after ack
        end
    end

    assign wrCycle = wbAck && wbWe;

    // Side effects land in the ack cycle, dropped while a run is active
    assign operandWr.isWeight = inWeights;
    assign operandWr.index    = wbAdr[3:0];
    assign operandWr.data     = wbDatW;
    assign operandWrEn        = wrCycle && (inWeights || inActs) && !busy;
    assign start              = wrCycle && inCtrl && !busy;  // Restart while busy ignored

    assign resultRdIdx = wbAdr[3:0];

    // Read mux, operand stores are write only
    always_comb begin
        wbDatR = '0;
        if (inCtrl) begin
            wbDatR = wbDatT'(status);
        end else if (inResults) begin
            wbDatR = wbDatT'(resultRdData);  // Zero extend 7 bit result
        end
    end

endmodule

/* rtl/macCell.sv */
module macCell
    import tpuPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  weightT weightIn,
    input  logic   loadWeight,
    input  actT    actIn,
    input  psumT   psumIn,
    output weightT weightOut,
    output actT    actOut,
    output psumT   psumOut
);

    psumT product;

    // Activation is unsigned, zero extend before the signed multiply
    assign product = psumT'(weightOut) * psumT'({1'b0, actIn});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weightOut <= '0;
            actOut    <= '0;
            psumOut   <= '0;
        end else begin
            if (loadWeight) begin
                weightOut <= weightIn;     // Shift down during preload
            end
            actOut  <= actIn;              // One hop right
            psumOut <= psumIn + product;   // One hop down
        end
    end

endmodule

/* rtl/operandStore.sv */
module operandStore
    import tpuPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  operandWrT operandWr,
    input  logic      operandWrEn,
    input  runStateT  phase,
    input  cntT       count,
    output arrayFeedT feed
);

    weightT    weights [ResultCount];  // Index k*4 + c
    actT       acts    [ResultCount];  // Index r*4 + k
    arrayFeedT feedNext;

    // ======================================================================
    // Register files, written from the bus
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ResultCount; i++) begin
                weights[i] <= '0;
                acts[i]    <= '0;
            end
        end else if (operandWrEn) begin
            if (operandWr.isWeight) begin
                weights[operandWr.index] <= weightT'(operandWr.data);
            end else begin
                acts[operandWr.index] <= actT'(operandWr.data);  // Top bit dropped
            end
        end
    end

    // ======================================================================
    // Feed toward the array
    // ======================================================================
    always_comb begin
        int wRow;  // Weight row pushed this step
        int aRow;  // Activation row seen by one array row
        feedNext = '0;
        wRow     = 0;
        aRow     = 0;
        case (phase)
            PreloadWeights: begin
                // Bottom row first, it shifts furthest down
                feedNext.loadWeights = 1'b1;
                wRow = ArraySize - 1 - int'(count);
                for (int c = 0; c < ArraySize; c++) begin
                    feedNext.weightRow[c] = weights[wRow * ArraySize + c];
                end
            end
            Stream: begin
                // Row k lags row k-1 by one cycle
                for (int k = 0; k < ArraySize; k++) begin
                    aRow = int'(count) - k;
                    if (aRow >= 0 && aRow < ArraySize) begin
                        feedNext.actColumn[k] = acts[aRow * ArraySize + k];
                    end
                end
            end
            default: ;  // Zeros keep the grid quiet
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            feed <= '0;
        end else begin
            feed <= feedNext;  // One cycle after phase/count
        end
    end

endmodule

/* rtl/resultBuffer.sv */
module resultBuffer
    import tpuPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 captureEn,
    input  logic                 clearResults,
    input  cntT                  count,
    input  psumT [ArraySize-1:0] colSums,
    input  idxT                  resultRdIdx,
    output resultT               resultRdData
);

    resultT results [ResultCount];  // Unified buffer, index r*4 + c
    logic   inDrain;                // Count restarted after the stream phase
    cntT    stepNow;                // Steps since stream start
    cntT    stepQ;                  // Capture step, one cycle old
    logic   capQ;

    // ReLU, then clamp to the 7 bit range
    function automatic resultT reluSat(input psumT v);
        if (v < 0) begin
            return '0;
        end else if (v > psumT'(ResultMax)) begin
            return resultT'(ResultMax);
        end
        return resultT'(v);
    endfunction

    assign stepNow = inDrain ? cntT'(StreamCycles) + count : count;

    // ======================================================================
    // Step tracking across stream and drain
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inDrain <= 1'b0;
            stepQ   <= '0;
            capQ    <= 1'b0;
        end else begin
            stepQ <= stepNow;
            capQ  <= captureEn;  // Last column sum leaves after drain ends
            if (!captureEn) begin
                inDrain <= 1'b0;
            end else if (count == cntT'(StreamCycles - 1)) begin
                inDrain <= 1'b1;
            end
        end
    end

    // Column c holds row r at captured step r + c + ArraySize
    always_ff @(posedge clk or posedge rst) begin
        int r;
        if (rst) begin
            for (int i = 0; i < ResultCount; i++) results[i] <= '0;
        end else if (clearResults) begin
            for (int i = 0; i < ResultCount; i++) results[i] <= '0;
        end else if (capQ) begin
            for (int c = 0; c < ArraySize; c++) begin
                r = int'(stepQ) - c - ArraySize;
                if (r >= 0 && r < ArraySize) begin
                    results[r * ArraySize + c] <= reluSat(colSums[c]);
                end
            end
        end
    end

    assign resultRdData = results[resultRdIdx];  // Read port for the bus

endmodule

/* rtl/sequenceControl.sv */
module sequenceControl
    import tpuPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  logic     phaseLast,
    output runStateT phase,
    output logic     captureEn,
    output logic     clearResults,
    output logic     busy,
    output statusT   status
);

    runStateT state, stateNext;
    logic     done;  // Sticky until the next start

    // ======================================================================
    // Run FSM
    // ======================================================================
    always_comb begin
        stateNext = state;
        case (state)
            Idle:           if (start)     stateNext = PreloadWeights;
            PreloadWeights: if (phaseLast) stateNext = Stream;
            Stream:         if (phaseLast) stateNext = Drain;
            Drain:          if (phaseLast) stateNext = Idle;
            default:                       stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= Idle;
            done  <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == Idle && start) begin
                done <= 1'b0;  // New job, old result no longer current
            end else if (state == Drain && phaseLast) begin
                done <= 1'b1;
            end
        end
    end

    assign phase        = state;
    assign busy         = (state != Idle);
    assign clearResults = (state == Idle) && start;             // Wipe old results at launch
    assign captureEn    = (state == Stream) || (state == Drain);  // Column outputs may be live

    assign status.done = done;
    assign status.busy = busy;

endmodule

/* rtl/stepCounter.sv */
module stepCounter
    import tpuPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  runStateT phase,
    output cntT      count,
    output logic     phaseLast
);

    // Final count of the current phase
    always_comb begin
        case (phase)
            PreloadWeights: phaseLast = (count == cntT'(PreloadCycles - 1));
            Stream:         phaseLast = (count == cntT'(StreamCycles - 1));
            Drain:          phaseLast = (count == cntT'(DrainCycles - 1));
            default:        phaseLast = 1'b0;  // Idle has no end
        endcase
    end

    // Phase moves on exactly at phaseLast, so wrap there
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (phase == Idle || phaseLast) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

/* rtl/systolicArray.sv */
module systolicArray
    import tpuPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  arrayFeedT            feed,
    output psumT [ArraySize-1:0] colSums
);

    // Edge nets carry one extra row or column for the grid borders
    weightT weightNet [ArraySize+1][ArraySize];
    actT    actNet    [ArraySize][ArraySize+1];
    psumT   psumNet   [ArraySize+1][ArraySize];

    // ======================================================================
    // Grid of cells, weights and sums go down, activations go right
    // ======================================================================
    for (genvar k = 0; k < ArraySize; k++) begin : gRow
        assign actNet[k][0] = feed.actColumn[k];  // Left edge
        for (genvar c = 0; c < ArraySize; c++) begin : gCol
            macCell i_macCell (
                .clk(clk), .rst(rst),
                .weightIn(weightNet[k][c]), .loadWeight(feed.loadWeights),
                .actIn(actNet[k][c]), .psumIn(psumNet[k][c]),
                .weightOut(weightNet[k+1][c]), .actOut(actNet[k][c+1]),
                .psumOut(psumNet[k+1][c])
            );
        end
    end

    for (genvar c = 0; c < ArraySize; c++) begin : gEdge
        assign weightNet[0][c] = feed.weightRow[c];  // Top edge
        assign psumNet[0][c]   = '0;                 // Columns start from zero
        assign colSums[c]      = psumNet[ArraySize][c];
    end

endmodule

/* rtl/tpuPkg.sv */
package tpuPkg;

    // ======================================================================
    // Array geometry and limits
    // ======================================================================
    localparam int ArraySize   = 4;                      // Rows and columns of the grid
    localparam int ResultCount = ArraySize * ArraySize;  // One word per row/column pair
    localparam int ResultMax   = 127;                    // Clamp after ReLU

    // Phase lengths in cycles
    localparam int PreloadCycles = ArraySize;            // One weight row per shift
    localparam int StreamCycles  = 2 * ArraySize - 1;    // Skewed diagonal needs 2N-1 steps
    localparam int DrainCycles   = ArraySize;            // Let the last sums leave the grid

    // ======================================================================
    // Data widths
    // ======================================================================
    typedef logic signed [7:0]  weightT;   // Full 8 bit signed weight
    typedef logic        [6:0]  actT;      // Unsigned activation
    typedef logic signed [16:0] psumT;     // 15 bit product plus 2 bits of growth
    typedef logic        [6:0]  resultT;   // ReLU output, saturated
    typedef logic        [5:0]  wbAdrT;    // Word address on the bus
    typedef logic        [7:0]  wbDatT;    // Bus data
    typedef logic        [3:0]  idxT;      // Flat index into a 4x4 matrix
    typedef logic        [3:0]  cntT;      // Cycle count inside one phase

    // Address map
    localparam wbAdrT WeightBase = 6'h00;  // k*4 + c
    localparam wbAdrT ActBase    = 6'h10;  // r*4 + k
    localparam wbAdrT CtrlAddr   = 6'h20;  // Write starts, read gives status
    localparam wbAdrT ResultBase = 6'h30;  // r*4 + c

    // Run FSM
    typedef enum logic [1:0] {
        Idle,
        PreloadWeights,
        Stream,
        Drain
    } runStateT;

    // ======================================================================
    // Bundles between blocks
    // ======================================================================
    typedef struct packed {
        logic  isWeight;  // 1 = weight store, 0 = activation store
        idxT   index;
        wbDatT data;
    } operandWrT;

    typedef struct packed {
        weightT [ArraySize-1:0] weightRow;  // Enters the top of each column
        actT    [ArraySize-1:0] actColumn;  // Enters the left of each row
        logic                   loadWeights;
    } arrayFeedT;

    // Status word as seen on the bus, busy in bit0
    typedef struct packed {
        logic done;
        logic busy;
    } statusT;

endpackage

/* rtl/tpuTop.sv */
module tpuTop
    import tpuPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    // Wishbone classic slave
    input  logic  wbCyc,
    input  logic  wbStb,
    input  logic  wbWe,
    input  wbAdrT wbAdr,
    input  wbDatT wbDatW,
    output wbDatT wbDatR,
    output logic  wbAck
);

    // ======================================================================
    // Interconnect
    // ======================================================================
    operandWrT operandWr;     // Bus to operand store
    logic      operandWrEn;
    logic      start;         // Run request, ack cycle only
    idxT       resultRdIdx;
    resultT    resultRdData;
    statusT    status;
    logic      busy;
    runStateT  phase;
    logic      captureEn;
    logic      clearResults;
    cntT       count;
    logic      phaseLast;
    arrayFeedT feed;
    psumT [ArraySize-1:0] colSums;  // Bottom edge of the grid

    busPort i_busPort (
        .clk(clk), .rst(rst),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck),
        .busy(busy), .status(status), .resultRdData(resultRdData),
        .operandWr(operandWr), .operandWrEn(operandWrEn),
        .start(start), .resultRdIdx(resultRdIdx)
    );

    sequenceControl i_sequenceControl (
        .clk(clk), .rst(rst), .start(start), .phaseLast(phaseLast),
        .phase(phase), .captureEn(captureEn), .clearResults(clearResults),
        .busy(busy), .status(status)
    );

    stepCounter i_stepCounter (
        .clk(clk), .rst(rst), .phase(phase), .count(count), .phaseLast(phaseLast)
    );

    operandStore i_operandStore (
        .clk(clk), .rst(rst), .operandWr(operandWr), .operandWrEn(operandWrEn),
        .phase(phase), .count(count), .feed(feed)
    );

    systolicArray i_systolicArray (
        .clk(clk), .rst(rst), .feed(feed), .colSums(colSums)
    );

    resultBuffer i_resultBuffer (
        .clk(clk), .rst(rst), .captureEn(captureEn), .clearResults(clearResults),
        .count(count), .colSums(colSums),
        .resultRdIdx(resultRdIdx), .resultRdData(resultRdData)
    );

endmodule
